//--- sim.f
+incdir+common
common/noc_msg_pkg.sv
common/eth_msg_pkg.sv
logic/ingress_fifo.sv
ingress_load_balance/ingress_frame_buf.sv
ingress_load_balance/ingress_dest_sel.sv
ingress_load_balance/ingress_noc_out.sv
ingress_load_balance/ingress_load_balance.sv
dv/ingress_checker.sv
dv/tb_ingress_load_balance.sv

//--- Bender.yml
package:
  name: ingress_load_balance

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/noc_msg_pkg.sv
      - common/eth_msg_pkg.sv
      - logic/ingress_fifo.sv
      - ingress_load_balance/ingress_frame_buf.sv
      - ingress_load_balance/ingress_dest_sel.sv
      - ingress_load_balance/ingress_noc_out.sv
      - ingress_load_balance/ingress_load_balance.sv

  - target: simulation
    include_dirs:
      - common
    files:
      - dv/ingress_checker.sv
      - dv/tb_ingress_load_balance.sv

//--- dv/tb_ingress_load_balance.sv
`default_nettype none

`include "ingress_load_balance_defs.svh"

module tb_ingress_load_balance;

    timeunit 1ns;
    timeprecision 1ps;

    import eth_msg_pkg::*;

    localparam int BEAT_TIMEOUT  = 2000;
    localparam int FRAME_TIMEOUT = 20000;

    logic                       clk;
    logic                       rst;
    logic                       in_val;
    eth_beat_t                  in_beat;
    logic                       in_rdy;
    logic [`NUM_DST-1:0]        dst_en;
    logic                       noc_val;
    logic [`NOC_DATA_WIDTH-1:0] noc_data;
    logic                       noc_rdy;

    int                         chk_errors;
    int                         frames_done;
    int                         tb_errors;
    int                         frames_sent;
    int                         tests;
    int                         failed_tests;
    int                         seed;
    bit                         stall_en;

    ingress_load_balance ingress_load_balance_inst (
         .clk      (clk)
        ,.rst      (rst)
        ,.in_val   (in_val)
        ,.in_beat  (in_beat)
        ,.in_rdy   (in_rdy)
        ,.dst_en   (dst_en)
        ,.noc_val  (noc_val)
        ,.noc_data (noc_data)
        ,.noc_rdy  (noc_rdy)
    );

    ingress_checker ingress_checker_inst (
         .clk         (clk)
        ,.rst         (rst)
        ,.in_val      (in_val)
        ,.in_beat     (in_beat)
        ,.in_rdy      (in_rdy)
        ,.dst_en      (dst_en)
        ,.noc_val     (noc_val)
        ,.noc_data    (noc_data)
        ,.noc_rdy     (noc_rdy)
        ,.errors      (chk_errors)
        ,.frames_done (frames_done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // noc back-pressure, roughly one stall in four when enabled
    initial begin
        noc_rdy = 1'b1;
        forever begin
            @(negedge clk);
            noc_rdy = stall_en ? ({$random(seed)} % 4 != 0) : 1'b1;
        end
    end

    function automatic int error_total();
        return chk_errors + tb_errors;
    endfunction

    task automatic send_frame(input int nbytes, input bit gaps);
        int        nbeats;
        int        waited;
        int        idle;
        eth_beat_t b;
        nbeats = (nbytes + 7) / 8;
        for (int i = 0; i < nbeats; i++) begin
            if (gaps) begin
                idle = {$random(seed)} % 3;
                repeat (idle) @(negedge clk);
            end
            b.data     = {$random(seed), $random(seed)};
            b.last     = (i == nbeats - 1);
            b.padbytes = b.last ? 3'(nbeats * 8 - nbytes) : 3'd0;
            in_beat = b;
            in_val  = 1'b1;
            waited  = 0;
            while (!in_rdy && waited < BEAT_TIMEOUT) begin  // in_rdy only moves at posedge
                @(negedge clk);
                waited++;
            end
            if (!in_rdy) begin
                tb_errors++;
                $display("timeout: input beat %0d not accepted after %0d cycles", i, waited);
            end
            @(negedge clk);
            in_val = 1'b0;
        end
        frames_sent++;
    endtask

    task automatic wait_frames(input int target);
        int waited;
        waited = 0;
        while (frames_done < target && waited < FRAME_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (frames_done < target) begin
            tb_errors++;
            $display("timeout: only %0d of %0d frames came out of the NoC port",
                     frames_done, target);
        end
    endtask

    task automatic report_test(input string name, input int mark);
        tests++;
        if (error_total() == mark) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: %0d errors", tests, name, error_total() - mark);
        end
    endtask

    initial begin
        int mark;
        seed         = 32'h6b7da034;
        rst          = 1'b1;
        in_val       = 1'b0;
        in_beat      = '0;
        dst_en       = 4'b1111;
        stall_en     = 1'b0;
        tb_errors    = 0;
        frames_sent  = 0;
        tests        = 0;
        failed_tests = 0;
        repeat (3) @(negedge clk);
        rst = 1'b0;

        mark = error_total();
        send_frame(60, 1'b0);
        wait_frames(frames_sent);
        report_test("single 60-byte frame", mark);

        mark = error_total();
        send_frame(8, 1'b0);
        send_frame(64, 1'b0);
        send_frame(256, 1'b0);
        send_frame(1, 1'b0);
        send_frame(9, 1'b0);
        wait_frames(frames_sent);
        report_test("frame size rounding", mark);

        mark = error_total();
        repeat (40) send_frame(1 + {$random(seed)} % 256, 1'b0);
        wait_frames(frames_sent);
        report_test("round robin over all tiles", mark);

        mark = error_total();
        stall_en = 1'b1;
        repeat (20) send_frame(1 + {$random(seed)} % 256, 1'b1);
        wait_frames(frames_sent);
        stall_en = 1'b0;
        report_test("stalls and input gaps", mark);

        mark = error_total();
        dst_en = 4'b1010;  // tiles at x = 2 and x = 4
        repeat (6) send_frame(1 + {$random(seed)} % 256, 1'b0);
        wait_frames(frames_sent);
        report_test("partial tile mask", mark);

        mark = error_total();
        dst_en = 4'b0000;
        send_frame(60, 1'b0);
        for (int c = 0; c < 200; c++) begin
            @(negedge clk);
            if (noc_val) begin
                tb_errors++;
                $display("noc_val went high at cycle %0d with no tile enabled", c);
            end
        end
        dst_en = 4'b1111;
        wait_frames(frames_sent);
        report_test("no tile enabled", mark);

        $display("%0d tests, %0d failed, %0d frames checked, %0d errors",
                 tests, failed_tests, frames_done, error_total());
        if (error_total() == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/ingress_checker.sv
`default_nettype none

`include "ingress_load_balance_defs.svh"

module ingress_checker (
     input  wire                            clk
    ,input  wire                            rst
    ,input  wire                            in_val
    ,input  wire eth_msg_pkg::eth_beat_t    in_beat
    ,input  wire                            in_rdy
    ,input  wire  [`NUM_DST-1:0]            dst_en
    ,input  wire                            noc_val
    ,input  wire  [`NOC_DATA_WIDTH-1:0]     noc_data
    ,input  wire                            noc_rdy
    ,output int                             errors
    ,output int                             frames_done
);

    timeunit 1ns;
    timeprecision 1ps;

    import noc_msg_pkg::*;

    logic [`NOC_DATA_WIDTH-1:0] exp_data [$];
    int                         exp_size [$];
    int                         byte_acc;
    int                         rr_ptr;
    int                         flits_left;
    bit                         want_hdr;

    // first enabled tile at or after ptr, -1 when the mask is empty
    function automatic int next_dest(input logic [`NUM_DST-1:0] en, input int ptr);
        int idx;
        next_dest = -1;
        for (int k = `NUM_DST - 1; k >= 0; k--) begin
            idx = (ptr + k) % `NUM_DST;
            if (en[idx]) begin
                next_dest = idx;
            end
        end
    endfunction

    function automatic logic [`NOC_DATA_WIDTH-1:0] expected_header(input int fsize,
                                                                   input int dst);
        eth_rx_hdr_flit_t h;
        h = '0;
        h.core.dst_x_coord = `XY_WIDTH'(`DST_X_BASE + dst);
        h.core.dst_y_coord = `XY_WIDTH'(`DST_Y);
        h.core.dst_fbits   = `PKT_IF_FBITS;
        h.core.msg_len     = `MSG_LENGTH_WIDTH'((fsize + 7) / 8);
        h.core.msg_type    = ETH_RX_FRAME;
        h.core.src_x_coord = '0;  // top level built with source 0,0
        h.core.src_y_coord = '0;
        h.core.src_fbits   = `PKT_IF_FBITS;
        h.frame_size       = `MTU_SIZE_W'(fsize);
        return h;
    endfunction

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        if (exp !== act) begin
            errors++;
            $display("[FAIL] %s expected %h got %h (frame %0d)", name, exp, act, frames_done);
        end
    endtask

    always @(posedge clk) begin
        int fsize;
        int dst;
        if (rst) begin
            exp_data.delete();
            exp_size.delete();
            byte_acc    = 0;
            rr_ptr      = 0;
            flits_left  = 0;
            want_hdr    = 1'b1;
            errors      = 0;
            frames_done = 0;
        end else begin
            if (noc_val && noc_rdy) begin
                if (want_hdr) begin
                    dst = next_dest(dst_en, rr_ptr);
                    if (exp_size.size() == 0) begin
                        errors++;
                        $display("header flit sent with no complete frame buffered");
                    end else if (dst < 0) begin
                        errors++;
                        $display("header flit sent while no destination tile is enabled");
                    end else begin
                        fsize = exp_size.pop_front();
                        check_value("noc_data(header)", expected_header(fsize, dst), noc_data);
                        rr_ptr     = (dst + 1) % `NUM_DST;
                        flits_left = (fsize + 7) / 8;
                        want_hdr   = 1'b0;
                    end
                end else begin
                    if (exp_data.size() == 0) begin
                        errors++;
                        $display("data flit sent with no input beat left to match it");
                    end else begin
                        check_value("noc_data", exp_data.pop_front(), noc_data);
                    end
                    flits_left--;
                    if (flits_left == 0) begin
                        want_hdr = 1'b1;
                        frames_done++;
                    end
                end
            end
            if (in_val && in_rdy) begin
                exp_data.push_back(in_beat.data);
                byte_acc += 8 - int'(in_beat.padbytes);  // padbytes only set on a last beat
                if (in_beat.last) begin
                    exp_size.push_back(byte_acc);
                    byte_acc = 0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- ingress_load_balance/ingress_load_balance.sv
`default_nettype none

`include "ingress_load_balance_defs.svh"

module ingress_load_balance #(
     parameter logic [`XY_WIDTH-1:0] SRC_X = '0
    ,parameter logic [`XY_WIDTH-1:0] SRC_Y = '0
)(
     input  wire                            clk
    ,input  wire                            rst

    ,input  wire                            in_val
    ,input  wire eth_msg_pkg::eth_beat_t    in_beat
    ,output logic                           in_rdy

    ,input  wire  [`NUM_DST-1:0]            dst_en

    ,output logic                           noc_val
    ,output logic [`NOC_DATA_WIDTH-1:0]     noc_data
    ,input  wire                            noc_rdy
);

    import eth_msg_pkg::*;

    logic                   size_val;
    logic [`MTU_SIZE_W-1:0] size;
    logic                   size_rdy;

    logic                   req_val;
    ingress_req_t           req;
    logic                   req_rdy;

    logic                   beat_val;
    eth_beat_t              beat;
    logic                   beat_rdy;

    ingress_frame_buf frame_buf (
         .clk      (clk)
        ,.rst      (rst)
        ,.in_val   (in_val)
        ,.in_beat  (in_beat)
        ,.in_rdy   (in_rdy)
        ,.beat_val (beat_val)
        ,.beat     (beat)
        ,.beat_rdy (beat_rdy)
        ,.size_val (size_val)
        ,.size     (size)
        ,.size_rdy (size_rdy)
    );

    ingress_dest_sel dest_sel (
         .clk      (clk)
        ,.rst      (rst)
        ,.dst_en   (dst_en)
        ,.size_val (size_val)
        ,.size     (size)
        ,.size_rdy (size_rdy)
        ,.req_val  (req_val)
        ,.req      (req)
        ,.req_rdy  (req_rdy)
    );

    ingress_noc_out #(
         .SRC_X (SRC_X)
        ,.SRC_Y (SRC_Y)
    ) noc_out (
         .clk      (clk)
        ,.rst      (rst)
        ,.req_val  (req_val)
        ,.req      (req)
        ,.req_rdy  (req_rdy)
        ,.beat_val (beat_val)
        ,.beat     (beat)
        ,.beat_rdy (beat_rdy)
        ,.noc_val  (noc_val)
        ,.noc_data (noc_data)
        ,.noc_rdy  (noc_rdy)
    );

endmodule

`default_nettype wire

//--- ingress_load_balance/ingress_noc_out.sv
`default_nettype none

`include "ingress_load_balance_defs.svh"

module ingress_noc_out #(
     parameter logic [`XY_WIDTH-1:0] SRC_X = '0
    ,parameter logic [`XY_WIDTH-1:0] SRC_Y = '0
)(
     input  wire                            clk
    ,input  wire                            rst

    ,input  wire                            req_val
    ,input  wire eth_msg_pkg::ingress_req_t req
    ,output logic                           req_rdy

    ,input  wire                            beat_val
    ,input  wire eth_msg_pkg::eth_beat_t    beat
    ,output logic                           beat_rdy

    ,output logic                           noc_val
    ,output logic [`NOC_DATA_WIDTH-1:0]     noc_data
    ,input  wire                            noc_rdy
);

    import noc_msg_pkg::*;

    typedef enum logic {
        HDR  = 1'b0,
        DATA = 1'b1
    } state_e;

    typedef enum logic {
        HDR_FLIT   = 1'b0,
        DATA_FLITS = 1'b1
    } out_sel_e;

    state_e                 state_reg;
    state_e                 state_next;
    out_sel_e               out_sel;
    eth_rx_hdr_flit_t       hdr_flit;
    logic [`MTU_SIZE_W-1:0] flit_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= HDR;
        end else begin
            state_reg <= state_next;
        end
    end

    always_comb begin
        req_rdy    = 1'b0;
        beat_rdy   = 1'b0;
        noc_val    = 1'b0;
        out_sel    = HDR_FLIT;
        state_next = state_reg;
        case (state_reg)
            HDR: begin
                // header goes out only once the first data beat is already waiting
                if (req_val & beat_val & noc_rdy) begin
                    req_rdy    = 1'b1;
                    noc_val    = 1'b1;
                    state_next = DATA;
                end
            end
            DATA: begin
                out_sel  = DATA_FLITS;
                beat_rdy = noc_rdy;
                noc_val  = beat_val;
                if (noc_rdy & beat_val & beat.last) begin
                    state_next = HDR;
                end
            end
            default: begin
                state_next = HDR;
            end
        endcase
    end

    // bytes / 8, rounded up
    assign flit_cnt = (req.frame_size >> `NOC_DATA_BYTES_W)
                    + `MTU_SIZE_W'(|req.frame_size[`NOC_DATA_BYTES_W-1:0]);

    always_comb begin
        hdr_flit = '0;
        hdr_flit.core.dst_x_coord = req.dst_x;
        hdr_flit.core.dst_y_coord = req.dst_y;
        hdr_flit.core.dst_fbits   = `PKT_IF_FBITS;
        hdr_flit.core.msg_len     = flit_cnt[`MSG_LENGTH_WIDTH-1:0];
        hdr_flit.core.msg_type    = ETH_RX_FRAME;
        hdr_flit.core.src_x_coord = SRC_X;
        hdr_flit.core.src_y_coord = SRC_Y;
        hdr_flit.core.src_fbits   = `PKT_IF_FBITS;
        hdr_flit.frame_size       = req.frame_size;
    end

    assign noc_data = (out_sel == HDR_FLIT) ? hdr_flit : beat.data;

endmodule

`default_nettype wire

//--- ingress_load_balance/ingress_dest_sel.sv
`default_nettype none

`include "ingress_load_balance_defs.svh"

module ingress_dest_sel (
     input  wire                            clk
    ,input  wire                            rst

    ,input  wire  [`NUM_DST-1:0]            dst_en
    ,input  wire                            size_val
    ,input  wire  [`MTU_SIZE_W-1:0]         size
    ,output logic                           size_rdy

    ,output logic                           req_val
    ,output eth_msg_pkg::ingress_req_t      req
    ,input  wire                            req_rdy
);

    localparam int IDX_W = (`NUM_DST > 1) ? $clog2(`NUM_DST) : 1;

    logic [IDX_W-1:0] rr_ptr;
    logic [IDX_W-1:0] sel;
    logic             any_en;

    // first enabled tile at or after start, searching cyclically
    function automatic logic [IDX_W-1:0] pick(input logic [`NUM_DST-1:0] en,
                                              input logic [IDX_W-1:0] start);
        logic [IDX_W-1:0] idx;
        logic             found;
        pick  = start;
        found = 1'b0;
        for (int i = 0; i < `NUM_DST; i++) begin
            idx = IDX_W'((int'(start) + i) % `NUM_DST);
            if (!found && en[idx]) begin
                pick  = idx;
                found = 1'b1;
            end
        end
    endfunction

    assign any_en = |dst_en;
    assign sel    = pick(dst_en, rr_ptr);

    assign req_val  = size_val & any_en;
    assign size_rdy = req_rdy & any_en;

    assign req.dst_x      = `XY_WIDTH'(`DST_X_BASE) + `XY_WIDTH'(sel);
    assign req.dst_y      = `XY_WIDTH'(`DST_Y);
    assign req.frame_size = size;

    always_ff @(posedge clk) begin
        if (rst) begin
            rr_ptr <= '0;
        end else if (req_val & req_rdy) begin
            rr_ptr <= (sel == IDX_W'(`NUM_DST - 1)) ? '0 : sel + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- ingress_load_balance/ingress_frame_buf.sv
`default_nettype none

`include "ingress_load_balance_defs.svh"

module ingress_frame_buf (
     input  wire                            clk
    ,input  wire                            rst

    ,input  wire                            in_val
    ,input  wire eth_msg_pkg::eth_beat_t    in_beat
    ,output logic                           in_rdy

    ,output logic                           beat_val
    ,output eth_msg_pkg::eth_beat_t         beat
    ,input  wire                            beat_rdy

    ,output logic                           size_val
    ,output logic [`MTU_SIZE_W-1:0]         size
    ,input  wire                            size_rdy
);

    import eth_msg_pkg::*;

    logic                   run;        // low for the first cycle out of reset
    logic                   beat_wr_rdy;
    logic                   size_wr_rdy;
    logic                   accept;
    logic [3:0]             beat_bytes;
    logic [`MTU_SIZE_W-1:0] byte_cnt;
    logic [`MTU_SIZE_W-1:0] frame_total;

    assign in_rdy = run & beat_wr_rdy & size_wr_rdy;
    assign accept = in_val & in_rdy;

    // a last beat carries 8 - padbytes valid bytes
    assign beat_bytes  = 4'd8 - {1'b0, in_beat.padbytes};
    assign frame_total = byte_cnt + `MTU_SIZE_W'(beat_bytes);

    always_ff @(posedge clk) begin
        if (rst) begin
            run      <= 1'b0;
            byte_cnt <= '0;
        end else begin
            run <= 1'b1;
            if (accept) begin
                byte_cnt <= in_beat.last ? '0 : frame_total;
            end
        end
    end

    ingress_fifo #(
         .WIDTH ($bits(eth_beat_t))
        ,.DEPTH (`FRAME_BUF_DEPTH)
    ) beat_fifo (
         .clk     (clk)
        ,.rst     (rst)
        ,.wr_val  (in_val & run & size_wr_rdy)
        ,.wr_data (in_beat)
        ,.wr_rdy  (beat_wr_rdy)
        ,.rd_val  (beat_val)
        ,.rd_data (beat)
        ,.rd_rdy  (beat_rdy)
    );

    ingress_fifo #(
         .WIDTH (`MTU_SIZE_W)
        ,.DEPTH (`SIZE_FIFO_DEPTH)
    ) size_fifo (
         .clk     (clk)
        ,.rst     (rst)
        ,.wr_val  (in_val & in_beat.last & run & beat_wr_rdy)  // total of a complete frame
        ,.wr_data (frame_total)
        ,.wr_rdy  (size_wr_rdy)
        ,.rd_val  (size_val)
        ,.rd_data (size)
        ,.rd_rdy  (size_rdy)
    );

endmodule

`default_nettype wire

//--- logic/ingress_fifo.sv
`default_nettype none

module ingress_fifo #(
     parameter int WIDTH = 8
    ,parameter int DEPTH = 4
)(
     input  wire                clk
    ,input  wire                rst

    ,input  wire                wr_val
    ,input  wire  [WIDTH-1:0]   wr_data
    ,output logic               wr_rdy

    ,output logic               rd_val
    ,output logic [WIDTH-1:0]   rd_data
    ,input  wire                rd_rdy
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    assign wr_rdy  = (count != CNT_W'(DEPTH));
    assign rd_val  = (count != '0);
    assign rd_data = mem[rd_ptr];  // first word falls through

    assign do_wr = wr_val & wr_rdy;
    assign do_rd = rd_val & rd_rdy;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(do_wr) - CNT_W'(do_rd);
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

endmodule

`default_nettype wire

//--- common/eth_msg_pkg.sv
`default_nettype none

`include "ingress_load_balance_defs.svh"

package eth_msg_pkg;

    typedef struct packed {
        logic [`NOC_DATA_WIDTH-1:0]     data;
        logic                           last;
        logic [`NOC_PADBYTES_WIDTH-1:0] padbytes;  // zero except on a last beat
    } eth_beat_t;

    // handed from destination select to the noc output stage
    typedef struct packed {
        logic [`XY_WIDTH-1:0]   dst_x;
        logic [`XY_WIDTH-1:0]   dst_y;
        logic [`MTU_SIZE_W-1:0] frame_size;
    } ingress_req_t;

endpackage

`default_nettype wire

//--- common/noc_msg_pkg.sv
`default_nettype none

`include "ingress_load_balance_defs.svh"

package noc_msg_pkg;

    typedef enum logic [7:0] {
        ETH_RX_FRAME = 8'd16,
        ETH_TX_FRAME = 8'd17
    } noc_msg_type_e;

    typedef struct packed {
        logic [`XY_WIDTH-1:0]         dst_x_coord;
        logic [`XY_WIDTH-1:0]         dst_y_coord;
        logic [3:0]                   dst_fbits;
        logic [`MSG_LENGTH_WIDTH-1:0] msg_len;    // data flits after the header
        noc_msg_type_e                msg_type;
        logic [`XY_WIDTH-1:0]         src_x_coord;
        logic [`XY_WIDTH-1:0]         src_y_coord;
        logic [3:0]                   src_fbits;
    } noc_hdr_core_t;

    typedef struct packed {
        noc_hdr_core_t          core;
        logic [`MTU_SIZE_W-1:0] frame_size;
        logic [7:0]             reserved;
    } eth_rx_hdr_flit_t;

endpackage

`default_nettype wire

//--- common/ingress_load_balance_defs.svh
`ifndef INGRESS_LOAD_BALANCE_DEFS_SVH
`define INGRESS_LOAD_BALANCE_DEFS_SVH

`define NOC_DATA_WIDTH      64
`define NOC_DATA_BYTES_W    3   // log2 of bytes per flit
`define NOC_PADBYTES_WIDTH  3
`define XY_WIDTH            4
`define MSG_LENGTH_WIDTH    8
`define MTU_SIZE_W          16

// destination tiles sit in one row at x = DST_X_BASE + i
`define NUM_DST             4
`define DST_X_BASE          1
`define DST_Y               1

`define FRAME_BUF_DEPTH     64  // two max-size frames of 32 beats
`define SIZE_FIFO_DEPTH     8

`define PKT_IF_FBITS        4'b0010

`endif
